/* filelist.f */
+incdir+verif
verilog/ex_pkg.sv
verilog/ex_operand_sel.sv
verilog/ex_alu.sv
verilog/ex_branch.sv
verilog/csr_file.sv
verilog/ex_stage.sv
verif/ex_stage_sva.sv
verif/tb_ex_stage.sv

/* Makefile */
SRCS := $(shell grep -v '^+' filelist.f) verif/ex_stage_checks.svh

obj_dir/Vtb_ex_stage: $(SRCS) filelist.f
	verilator --binary --timing --assert -f filelist.f --top-module tb_ex_stage -o Vtb_ex_stage

run: obj_dir/Vtb_ex_stage
	./obj_dir/Vtb_ex_stage

clean:
	rm -rf obj_dir

.PHONY: run clean

/* verif/ex_stage_checks.svh */
// execute stage reference models and typed compare tasks, included by the testbench
`ifndef EX_STAGE_CHECKS_SVH
`define EX_STAGE_CHECKS_SVH

// rv32i integer rule, subtract only on the register form
function automatic ex_pkg::word_t alu_ref(
	input ex_pkg::op_class_t cls,
	input ex_pkg::alu_code_t code,
	input logic              sub,
	input ex_pkg::word_t     a,
	input ex_pkg::word_t     b
);
	logic [4:0] sh;
	sh = b[4:0];
	case (code)
		ex_pkg::ALU_ADD:  alu_ref = (sub && cls == ex_pkg::OP_ALU) ? a - b : a + b;
		ex_pkg::ALU_SLL:  alu_ref = a << sh;
		ex_pkg::ALU_SLT:  alu_ref = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		ex_pkg::ALU_SLTU: alu_ref = (a < b) ? 32'd1 : 32'd0;
		ex_pkg::ALU_XOR:  alu_ref = a ^ b;
		// bit 30 of the instruction picks the arithmetic shift
		ex_pkg::ALU_SR:   alu_ref = sub ? ex_pkg::word_t'($signed(a) >>> sh) : a >> sh;
		ex_pkg::ALU_OR:   alu_ref = a | b;
		default:          alu_ref = a & b;
	endcase
endfunction

// branch taken rule per funct3
function automatic logic br_ref(
	input ex_pkg::alu_code_t code,
	input ex_pkg::word_t     a,
	input ex_pkg::word_t     b
);
	case (code)
		ex_pkg::BR_BEQ:  br_ref = (a == b);
		ex_pkg::BR_BNE:  br_ref = (a != b);
		ex_pkg::BR_BLT:  br_ref = ($signed(a) < $signed(b));
		ex_pkg::BR_BGE:  br_ref = ($signed(a) >= $signed(b));
		ex_pkg::BR_BLTU: br_ref = (a < b);
		ex_pkg::BR_BGEU: br_ref = (a >= b);
		default:         br_ref = 1'b0;
	endcase
endfunction

task automatic check_word(input string what, input ex_pkg::word_t got, input ex_pkg::word_t exp);
	if (got !== exp) begin
		$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		abort_run();
	end
endtask

task automatic check_pc(input string what, input ex_pkg::pc_t got, input ex_pkg::pc_t exp);
	if (got !== exp) begin
		$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		abort_run();
	end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
	if (got !== exp) begin
		$display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
		abort_run();
	end
endtask

// whole EX/MA register at once
task automatic check_ma(
	input logic              ld,
	input logic              st,
	input logic              wbk,
	input ex_pkg::reg_adr_t  rd_adr,
	input ex_pkg::word_t     rd_data,
	input ex_pkg::word_t     st_data,
	input ex_pkg::alu_code_t code
);
	check_bit("cmd_ld_ma", cmd_ld_ma, ld);
	check_bit("cmd_st_ma", cmd_st_ma, st);
	check_bit("wbk_rd_reg_ma", wbk_rd_reg_ma, wbk);
	check_word("rd_adr_ma", {27'd0, rd_adr_ma}, {27'd0, rd_adr});
	check_word("rd_data_ma", rd_data_ma, rd_data);
	check_word("st_data_ma", st_data_ma, st_data);
	check_word("ldst_code_ma", {29'd0, ldst_code_ma}, {29'd0, code});
endtask

`endif

/* verif/tb_ex_stage.sv */
// execute stage testbench: directed ALU, memory, branch, CSR and trap tests
`timescale 1ns/1ps

module tb_ex_stage;

	localparam ex_pkg::pc_t MTVEC_RST = 30'h0000_0040;
	localparam int TIMEOUT_CYCLES = 2000;

	logic              clk;
	logic              rst_n;
	ex_pkg::op_class_t op_class_ex;
	ex_pkg::alu_code_t alu_code_ex;
	logic              alu_sub_ex;
	ex_pkg::word_t     rs1_data_ex;
	ex_pkg::word_t     rs2_data_ex;
	ex_pkg::word_t     imm_ex;
	ex_pkg::pc_t       pc_ex;
	ex_pkg::reg_adr_t  rd_adr_ex;
	logic              wbk_rd_reg_ex;
	ex_pkg::fwd_sel_t  fwd_rs1_ex;
	ex_pkg::fwd_sel_t  fwd_rs2_ex;
	ex_pkg::csr_adr_t  csr_adr_ex;
	ex_pkg::word_t     wbk_data_wb;
	ex_pkg::word_t     wbk_data_wb2;
	logic              stall;
	logic              cmd_ld_ma;
	logic              cmd_st_ma;
	ex_pkg::reg_adr_t  rd_adr_ma;
	ex_pkg::word_t     rd_data_ma;
	logic              wbk_rd_reg_ma;
	ex_pkg::word_t     st_data_ma;
	ex_pkg::alu_code_t ldst_code_ma;
	ex_pkg::pc_t       jmp_adr_ex;
	logic              jmp_condition_ex;
	logic              trap_condition_ex;
	logic              jmp_purge_ma;
	logic              csr_mie_bit;
	// forwarding select and csr address for the next issued instruction
	ex_pkg::fwd_sel_t  next_fwd;
	ex_pkg::csr_adr_t  next_csr;
	integer            seed;
	int                cycle_cnt;

	ex_stage #(
		.MTVEC_RESET (MTVEC_RST)
	) ex_stage_inst (
		.clk               (clk),
		.rst_n             (rst_n),
		.op_class_ex       (op_class_ex),
		.alu_code_ex       (alu_code_ex),
		.alu_sub_ex        (alu_sub_ex),
		.rs1_data_ex       (rs1_data_ex),
		.rs2_data_ex       (rs2_data_ex),
		.imm_ex            (imm_ex),
		.pc_ex             (pc_ex),
		.rd_adr_ex         (rd_adr_ex),
		.wbk_rd_reg_ex     (wbk_rd_reg_ex),
		.fwd_rs1_ex        (fwd_rs1_ex),
		.fwd_rs2_ex        (fwd_rs2_ex),
		.csr_adr_ex        (csr_adr_ex),
		.wbk_data_wb       (wbk_data_wb),
		.wbk_data_wb2      (wbk_data_wb2),
		.stall             (stall),
		.cmd_ld_ma         (cmd_ld_ma),
		.cmd_st_ma         (cmd_st_ma),
		.rd_adr_ma         (rd_adr_ma),
		.rd_data_ma        (rd_data_ma),
		.wbk_rd_reg_ma     (wbk_rd_reg_ma),
		.st_data_ma        (st_data_ma),
		.ldst_code_ma      (ldst_code_ma),
		.jmp_adr_ex        (jmp_adr_ex),
		.jmp_condition_ex  (jmp_condition_ex),
		.trap_condition_ex (trap_condition_ex),
		.jmp_purge_ma      (jmp_purge_ma),
		.csr_mie_bit       (csr_mie_bit)
	);

	`include "ex_stage_checks.svh"

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic abort_run();
		$display("Regression failed");
		$fatal(1);
	endtask

	// run limit
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			abort_run();
		end
	end

	// present one instruction at the rising edge, return at the falling edge
	task automatic issue(
		input ex_pkg::op_class_t op,
		input ex_pkg::alu_code_t code,
		input logic              sub,
		input ex_pkg::word_t     rs1,
		input ex_pkg::word_t     rs2,
		input ex_pkg::word_t     imm,
		input ex_pkg::pc_t       pc,
		input logic              wbk
	);
		@(posedge clk);
		op_class_ex   <= op;
		alu_code_ex   <= code;
		alu_sub_ex    <= sub;
		rs1_data_ex   <= rs1;
		rs2_data_ex   <= rs2;
		imm_ex        <= imm;
		pc_ex         <= pc;
		rd_adr_ex     <= 5'd7;
		wbk_rd_reg_ex <= wbk;
		fwd_rs1_ex    <= next_fwd;
		fwd_rs2_ex    <= next_fwd;
		csr_adr_ex    <= next_csr;
		@(negedge clk);
	endtask

	task automatic bubble();
		issue(ex_pkg::OP_NOP, 3'd0, 1'b0, 32'd0, 32'd0, 32'd0, 30'd0, 1'b0);
	endtask

	task automatic test_alu();
		ex_pkg::op_class_t cls;
		ex_pkg::word_t     a;
		ex_pkg::word_t     b;
		ex_pkg::word_t     exp;
		for (int c = 0; c < 2; c++) begin
			cls = (c == 0) ? ex_pkg::OP_ALU : ex_pkg::OP_ALUI;
			for (int s = 0; s < 2; s++) begin
				for (int k = 0; k < 8; k++) begin
					for (int n = 0; n < 10; n++) begin
						a = $random(seed);
						b = $random(seed);
						exp = alu_ref(cls, ex_pkg::alu_code_t'(k), s[0], a, b);
						issue(cls, ex_pkg::alu_code_t'(k), s[0], a, b, b, 30'd0, 1'b1);
						bubble();
						check_word("alu result", rd_data_ma, exp);
					end
				end
			end
		end
	endtask

	task automatic test_mem();
		ex_pkg::word_t src[4];
		ex_pkg::word_t base;
		ex_pkg::word_t sdat;
		logic          is_st;
		src[0] = 32'h1000_0100;
		src[1] = 32'h2000_0200;
		src[2] = 32'h3000_0300;
		src[3] = 32'h4000_0400;
		@(posedge clk);
		wbk_data_wb  <= src[2];
		wbk_data_wb2 <= src[3];
		for (int f = 0; f < 4; f++) begin
			for (int m = 0; m < 2; m++) begin
				is_st = m[0];
				// producer in MA feeds the FWD_MA case
				next_fwd = ex_pkg::FWD_NONE;
				issue(ex_pkg::OP_ALUI, ex_pkg::ALU_ADD, 1'b0, src[1], 32'd0, 32'd0, 30'd0, 1'b1);
				next_fwd = ex_pkg::fwd_sel_t'(f);
				issue(is_st ? ex_pkg::OP_ST : ex_pkg::OP_LD, 3'd2, 1'b0, src[0],
					32'h5555_aaaa, 32'h24, 30'd0, ~is_st);
				next_fwd = ex_pkg::FWD_NONE;
				base = (f == 0) ? src[0] : src[f];
				sdat = (f == 0) ? 32'h5555_aaaa : src[f];
				bubble();
				check_ma(~is_st, is_st, ~is_st, 5'd7, base + 32'h24, sdat, 3'd2);
			end
		end
		// store held in MA over a three cycle stall
		issue(ex_pkg::OP_ST, 3'd1, 1'b0, 32'h0000_8000, 32'h0bad_cafe, 32'h8, 30'd0, 1'b0);
		@(posedge clk);
		stall         <= 1'b1;
		// a jump waiting in EX must not steer fetch
		op_class_ex   <= ex_pkg::OP_JAL;
		wbk_rd_reg_ex <= 1'b1;
		repeat (3) begin
			@(negedge clk);
			check_ma(1'b0, 1'b1, 1'b0, 5'd7, 32'h0000_8008, 32'h0bad_cafe, 3'd1);
			check_bit("jump under stall", jmp_condition_ex, 1'b0);
		end
		@(posedge clk);
		stall <= 1'b0;
		bubble();
	endtask

	task automatic test_branch();
		ex_pkg::alu_code_t codes[6];
		ex_pkg::word_t     pa[5];
		ex_pkg::word_t     pb[5];
		ex_pkg::word_t     tgt;
		logic              taken;
		codes = '{ex_pkg::BR_BEQ, ex_pkg::BR_BNE, ex_pkg::BR_BLT,
			ex_pkg::BR_BGE, ex_pkg::BR_BLTU, ex_pkg::BR_BGEU};
		// equal, less both ways, greater both ways, and signed/unsigned disagreement
		pa = '{32'd7, 32'd1, 32'd2, 32'hffff_ffff, 32'd1};
		pb = '{32'd7, 32'd2, 32'd1, 32'd1, 32'hffff_ffff};
		tgt = {30'h100, 2'b00} + 32'h40;
		for (int i = 0; i < 6; i++) begin
			for (int j = 0; j < 5; j++) begin
				taken = br_ref(codes[i], pa[j], pb[j]);
				issue(ex_pkg::OP_BR, codes[i], 1'b0, pa[j], pb[j], 32'h40, 30'h100, 1'b0);
				check_bit("branch taken", jmp_condition_ex, taken);
				if (taken) begin
					check_pc("branch target", jmp_adr_ex, tgt[31:2]);
				end
				issue(ex_pkg::OP_ALUI, ex_pkg::ALU_ADD, 1'b0, 32'd1, 32'd0, 32'd1, 30'h101, 1'b1);
				check_bit("purge behind branch", jmp_purge_ma, taken);
				bubble();
				check_bit("write-back behind branch", wbk_rd_reg_ma, ~taken);
			end
		end
	endtask

	task automatic jump_case(
		input ex_pkg::op_class_t op,
		input ex_pkg::word_t     rs1,
		input ex_pkg::word_t     imm,
		input ex_pkg::pc_t       pc
	);
		ex_pkg::word_t tgt;
		tgt = ((op == ex_pkg::OP_JALR) ? rs1 : {pc, 2'b00}) + imm;
		issue(op, 3'd0, 1'b0, rs1, 32'd0, imm, pc, 1'b1);
		check_bit("jump taken", jmp_condition_ex, 1'b1);
		check_bit("no trap on jump", trap_condition_ex, 1'b0);
		check_pc("jump target", jmp_adr_ex, tgt[31:2]);
		issue(ex_pkg::OP_ALUI, ex_pkg::ALU_ADD, 1'b0, 32'd3, 32'd0, 32'd3, pc + 30'd1, 1'b1);
		check_word("link value", rd_data_ma, {pc, 2'b00} + 32'd4);
		check_bit("link write-back", wbk_rd_reg_ma, 1'b1);
		bubble();
		check_bit("write-back behind jump", wbk_rd_reg_ma, 1'b0);
	endtask

	task automatic test_upper();
		issue(ex_pkg::OP_LUI, 3'd0, 1'b0, 32'd0, 32'd0, 32'habcd_e000, 30'd0, 1'b1);
		bubble();
		check_word("lui", rd_data_ma, 32'habcd_e000);
		issue(ex_pkg::OP_AUIPC, 3'd0, 1'b0, 32'd0, 32'd0, 32'h0001_2000, 30'h40, 1'b1);
		bubble();
		check_word("auipc", rd_data_ma, {30'h40, 2'b00} + 32'h0001_2000);
	endtask

	// CSR instruction, its rd must show the value before the write
	task automatic csr_op(
		input ex_pkg::csr_op_t  op,
		input ex_pkg::csr_adr_t adr,
		input ex_pkg::word_t    src,
		input ex_pkg::word_t    old
	);
		next_csr = adr;
		issue(ex_pkg::OP_CSR, op, 1'b0, src, 32'd0, src, 30'h20, 1'b1);
		bubble();
		check_word("csr old value", rd_data_ma, old);
	endtask

	task automatic test_csr();
		ex_pkg::word_t a;
		ex_pkg::word_t b;
		ex_pkg::word_t c;
		a = 32'h1234_5678;
		b = 32'h0000_ff00;
		c = 32'h1030_0008;
		csr_op(ex_pkg::CSR_RW, ex_pkg::CSR_MSCRATCH, a, 32'd0);
		csr_op(ex_pkg::CSR_RS, ex_pkg::CSR_MSCRATCH, b, a);
		csr_op(ex_pkg::CSR_RC, ex_pkg::CSR_MSCRATCH, c, a | b);
		csr_op(ex_pkg::CSR_RS, ex_pkg::CSR_MSCRATCH, 32'd0, (a | b) & ~c);
		// write in the shadow of a taken branch is dropped
		issue(ex_pkg::OP_BR, ex_pkg::BR_BEQ, 1'b0, 32'd5, 32'd5, 32'h8, 30'h10, 1'b0);
		check_bit("branch before csr", jmp_condition_ex, 1'b1);
		next_csr = ex_pkg::CSR_MSCRATCH;
		issue(ex_pkg::OP_CSR, ex_pkg::CSR_RW, 1'b0, 32'hbad0_0bad, 32'd0, 32'd0, 30'h11, 1'b1);
		bubble();
		csr_op(ex_pkg::CSR_RS, ex_pkg::CSR_MSCRATCH, 32'd0, (a | b) & ~c);
		csr_op(ex_pkg::CSR_RS, 12'h7c0, 32'd0, 32'd0);
	endtask

	task automatic trap_case(input ex_pkg::op_class_t op, input ex_pkg::pc_t pc);
		issue(op, 3'd0, 1'b0, 32'd0, 32'd0, 32'd0, pc, 1'b1);
		check_bit("trap raised", trap_condition_ex, 1'b1);
		check_bit("no jump on trap", jmp_condition_ex, 1'b0);
		check_pc("trap vector", jmp_adr_ex, MTVEC_RST);
		bubble();
		check_bit("trap write-back", wbk_rd_reg_ma, (op == ex_pkg::OP_ECALL));
		check_bit("mie in handler", csr_mie_bit, 1'b0);
	endtask

	task automatic test_trap();
		csr_op(ex_pkg::CSR_RSI, ex_pkg::CSR_MSTATUS, 32'd8, 32'd0);
		check_bit("mie set", csr_mie_bit, 1'b1);
		trap_case(ex_pkg::OP_ECALL, 30'h123);
		csr_op(ex_pkg::CSR_RS, ex_pkg::CSR_MEPC, 32'd0, {30'h123, 2'b00});
		csr_op(ex_pkg::CSR_RS, ex_pkg::CSR_MCAUSE, 32'd0, 32'd11);
		issue(ex_pkg::OP_MRET, 3'd0, 1'b0, 32'd0, 32'd0, 32'd0, 30'h50, 1'b0);
		check_bit("mret jump", jmp_condition_ex, 1'b1);
		check_pc("mret target", jmp_adr_ex, 30'h123);
		bubble();
		check_bit("mie restored", csr_mie_bit, 1'b1);
		trap_case(ex_pkg::OP_ILLEGAL, 30'h77);
		csr_op(ex_pkg::CSR_RS, ex_pkg::CSR_MCAUSE, 32'd0, 32'd2);
		csr_op(ex_pkg::CSR_RS, ex_pkg::CSR_MEPC, 32'd0, {30'h77, 2'b00});
	endtask

	initial begin
		seed          = 32'h79fa_c112;
		cycle_cnt     = 0;
		next_fwd      = ex_pkg::FWD_NONE;
		next_csr      = 12'd0;
		rst_n         = 1'b0;
		stall         = 1'b0;
		op_class_ex   = ex_pkg::OP_NOP;
		alu_code_ex   = 3'd0;
		alu_sub_ex    = 1'b0;
		rs1_data_ex   = 32'd0;
		rs2_data_ex   = 32'd0;
		imm_ex        = 32'd0;
		pc_ex         = 30'd0;
		rd_adr_ex     = 5'd0;
		wbk_rd_reg_ex = 1'b0;
		fwd_rs1_ex    = ex_pkg::FWD_NONE;
		fwd_rs2_ex    = ex_pkg::FWD_NONE;
		csr_adr_ex    = 12'd0;
		wbk_data_wb   = 32'd0;
		wbk_data_wb2  = 32'd0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		bubble();
		test_alu();
		test_mem();
		test_branch();
		jump_case(ex_pkg::OP_JAL, 32'd0, 32'hffff_ffc0, 30'h200);
		jump_case(ex_pkg::OP_JALR, 32'h0000_3000, 32'h14, 30'h300);
		test_upper();
		test_csr();
		test_trap();
		$display("Regression passed");
		$finish;
	end

endmodule

/* verif/ex_stage_sva.sv */
// execute stage assertions on the EX/MA register, the purge slot and the fetch redirect
`timescale 1ns/1ps

module ex_stage_sva (
	input logic             clk,
	input logic             rst_n,
	input logic             stall,
	input logic             jmp_purge_ma,
	input logic             cmd_ld_ma,
	input logic             cmd_st_ma,
	input logic             wbk_rd_reg_ma,
	input logic             jmp_condition_ex,
	input logic             trap_condition_ex,
	input ex_pkg::reg_adr_t rd_adr_ma,
	input ex_pkg::word_t    rd_data_ma,
	input ex_pkg::word_t    st_data_ma
);

	// frozen register under stall
	hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> $stable({cmd_ld_ma, cmd_st_ma, wbk_rd_reg_ma, rd_adr_ma, rd_data_ma, st_data_ma}))
		else $error("EX/MA register changed under stall");

	// slot behind a redirect is killed
	purge_kills_slot: assert property (@(posedge clk) disable iff (!rst_n)
		(jmp_purge_ma && !stall) |=> !(cmd_ld_ma || cmd_st_ma || wbk_rd_reg_ma))
		else $error("purged instruction reached MA with a command");

	jump_trap_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(jmp_condition_ex && trap_condition_ex))
		else $error("jump and trap raised together");

endmodule

bind ex_stage ex_stage_sva ex_stage_sva_inst (
	.clk               (clk),
	.rst_n             (rst_n),
	.stall             (stall),
	.jmp_purge_ma      (jmp_purge_ma),
	.cmd_ld_ma         (cmd_ld_ma),
	.cmd_st_ma         (cmd_st_ma),
	.wbk_rd_reg_ma     (wbk_rd_reg_ma),
	.jmp_condition_ex  (jmp_condition_ex),
	.trap_condition_ex (trap_condition_ex),
	.rd_adr_ma         (rd_adr_ma),
	.rd_data_ma        (rd_data_ma),
	.st_data_ma        (st_data_ma)
);

/* verilog/ex_stage.sv */
// RV32I execute stage: operand forwarding, alu, branch, CSRs and the EX/MA register
`timescale 1ns/1ps

module ex_stage #(
	parameter ex_pkg::pc_t MTVEC_RESET = 30'd0
) (
	input  logic              clk,
	input  logic              rst_n,
	// from ID
	input  ex_pkg::op_class_t op_class_ex,
	input  ex_pkg::alu_code_t alu_code_ex,
	input  logic              alu_sub_ex,
	input  ex_pkg::word_t     rs1_data_ex,
	input  ex_pkg::word_t     rs2_data_ex,
	input  ex_pkg::word_t     imm_ex,
	input  ex_pkg::pc_t       pc_ex,
	input  ex_pkg::reg_adr_t  rd_adr_ex,
	input  logic              wbk_rd_reg_ex,
	input  ex_pkg::fwd_sel_t  fwd_rs1_ex,
	input  ex_pkg::fwd_sel_t  fwd_rs2_ex,
	input  ex_pkg::csr_adr_t  csr_adr_ex,
	// forwarding data
	input  ex_pkg::word_t     wbk_data_wb,
	input  ex_pkg::word_t     wbk_data_wb2,
	input  logic              stall,
	// to MA
	output logic              cmd_ld_ma,
	output logic              cmd_st_ma,
	output ex_pkg::reg_adr_t  rd_adr_ma,
	output ex_pkg::word_t     rd_data_ma,
	output logic              wbk_rd_reg_ma,
	output ex_pkg::word_t     st_data_ma,
	output ex_pkg::alu_code_t ldst_code_ma,
	// to IF
	output ex_pkg::pc_t       jmp_adr_ex,
	output logic              jmp_condition_ex,
	output logic              trap_condition_ex,
	// to ID
	output logic              jmp_purge_ma,
	output logic              csr_mie_bit
);

	ex_pkg::word_t     rs1_sel;
	ex_pkg::word_t     rs2_sel;
	ex_pkg::word_t     st_data;
	ex_pkg::word_t     adr_base;
	ex_pkg::word_t     adr_ofs;
	ex_pkg::word_t     alu_result;
	logic              cmp_eq;
	logic              cmp_lt;
	logic              cmp_ltu;
	ex_pkg::word_t     pcp4;
	ex_pkg::word_t     target;
	ex_pkg::pc_t       mtvec;
	ex_pkg::pc_t       mepc;
	ex_pkg::word_t     csr_rd_data;
	ex_pkg::op_class_t op_class_live;
	logic              csr_we;
	ex_pkg::word_t     rd_data_ex;
	logic              cmd_ld_ex;
	logic              cmd_st_ex;
	logic              wbk_ex;

	ex_operand_sel operand_sel_inst (
		.op_class_ex  (op_class_ex),
		.rs1_data_ex  (rs1_data_ex),
		.rs2_data_ex  (rs2_data_ex),
		.imm_ex       (imm_ex),
		.pc_ex        (pc_ex),
		.fwd_rs1_ex   (fwd_rs1_ex),
		.fwd_rs2_ex   (fwd_rs2_ex),
		.rd_data_ma   (rd_data_ma),
		.wbk_data_wb  (wbk_data_wb),
		.wbk_data_wb2 (wbk_data_wb2),
		.rs1_sel      (rs1_sel),
		.rs2_sel      (rs2_sel),
		.st_data      (st_data),
		.adr_base     (adr_base),
		.adr_ofs      (adr_ofs)
	);

	ex_alu alu_inst (
		.rs1_sel     (rs1_sel),
		.rs2_sel     (rs2_sel),
		.alu_code_ex (alu_code_ex),
		.alu_sub_ex  (alu_sub_ex),
		.op_class_ex (op_class_ex),
		.alu_result  (alu_result),
		.cmp_eq      (cmp_eq),
		.cmp_lt      (cmp_lt),
		.cmp_ltu     (cmp_ltu)
	);

	ex_branch branch_inst (
		.op_class_ex       (op_class_ex),
		.alu_code_ex       (alu_code_ex),
		.cmp_eq            (cmp_eq),
		.cmp_lt            (cmp_lt),
		.cmp_ltu           (cmp_ltu),
		.adr_base          (adr_base),
		.adr_ofs           (adr_ofs),
		.pc_ex             (pc_ex),
		.mtvec             (mtvec),
		.mepc              (mepc),
		.stall             (stall),
		.jmp_purge_ma      (jmp_purge_ma),
		.jmp_adr_ex        (jmp_adr_ex),
		.jmp_condition_ex  (jmp_condition_ex),
		.trap_condition_ex (trap_condition_ex),
		.pcp4              (pcp4),
		.target            (target)
	);

	// a purged instruction looks like a bubble to the CSR file
	assign op_class_live = jmp_purge_ma ? ex_pkg::OP_NOP : op_class_ex;
	assign csr_we = (op_class_ex == ex_pkg::OP_CSR) & ~jmp_purge_ma;

	csr_file #(
		.MTVEC_RESET (MTVEC_RESET)
	) csr_file_inst (
		.clk               (clk),
		.rst_n             (rst_n),
		.csr_we            (csr_we),
		.csr_adr_ex        (csr_adr_ex),
		.alu_code_ex       (alu_code_ex),
		.rs1_sel           (rs1_sel),
		.imm_ex            (imm_ex),
		.trap_condition_ex (trap_condition_ex),
		.op_class_ex       (op_class_live),
		.pc_ex             (pc_ex),
		.stall             (stall),
		.csr_rd_data       (csr_rd_data),
		.mtvec             (mtvec),
		.mepc              (mepc),
		.csr_mie_bit       (csr_mie_bit)
	);

	// rd result by class
	always_comb begin
		case (op_class_ex)
			ex_pkg::OP_LUI:                  rd_data_ex = imm_ex;
			ex_pkg::OP_JAL, ex_pkg::OP_JALR: rd_data_ex = pcp4;
			ex_pkg::OP_AUIPC:                rd_data_ex = target;
			ex_pkg::OP_CSR:                  rd_data_ex = csr_rd_data;
			default:                         rd_data_ex = alu_result;
		endcase
	end

	// kill memory and write-back of the slot behind a redirect
	assign cmd_ld_ex = (op_class_ex == ex_pkg::OP_LD) & ~jmp_purge_ma;
	assign cmd_st_ex = (op_class_ex == ex_pkg::OP_ST) & ~jmp_purge_ma;
	// illegal instructions never reach the register file
	assign wbk_ex = wbk_rd_reg_ex & ~jmp_purge_ma & (op_class_ex != ex_pkg::OP_ILLEGAL);

	// EX/MA register, frozen by stall
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd_ld_ma     <= 1'b0;
			cmd_st_ma     <= 1'b0;
			rd_adr_ma     <= 5'd0;
			rd_data_ma    <= 32'd0;
			wbk_rd_reg_ma <= 1'b0;
			st_data_ma    <= 32'd0;
			ldst_code_ma  <= 3'd0;
			jmp_purge_ma  <= 1'b0;
		end else if (!stall) begin
			cmd_ld_ma     <= cmd_ld_ex;
			cmd_st_ma     <= cmd_st_ex;
			rd_adr_ma     <= rd_adr_ex;
			rd_data_ma    <= rd_data_ex;
			wbk_rd_reg_ma <= wbk_ex;
			st_data_ma    <= st_data;
			ldst_code_ma  <= alu_code_ex;
			// next slot was fetched on the old path
			jmp_purge_ma  <= jmp_condition_ex | trap_condition_ex;
		end
	end

endmodule

/* verilog/csr_file.sv */
// machine-mode CSR file with read-modify-write, trap entry and mret
`timescale 1ns/1ps

module csr_file #(
	parameter ex_pkg::pc_t MTVEC_RESET = 30'd0
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              csr_we,
	input  ex_pkg::csr_adr_t  csr_adr_ex,
	input  ex_pkg::csr_op_t   alu_code_ex,
	input  ex_pkg::word_t     rs1_sel,
	input  ex_pkg::word_t     imm_ex,
	input  logic              trap_condition_ex,
	input  ex_pkg::op_class_t op_class_ex,
	input  ex_pkg::pc_t       pc_ex,
	input  logic              stall,
	output ex_pkg::word_t     csr_rd_data,
	output ex_pkg::pc_t       mtvec,
	output ex_pkg::pc_t       mepc,
	output logic              csr_mie_bit
);

	logic          mpie;
	ex_pkg::word_t mscratch;
	ex_pkg::word_t mcause;
	ex_pkg::word_t src;
	ex_pkg::word_t wdata;
	logic          wr_ok;
	logic          wr_en;
	logic          mret_en;
	logic          trap_en;

	// uimm forms have funct3 bit 2 set
	assign src = alu_code_ex[2] ? imm_ex : rs1_sel;

	// old value, the read happens before any write
	always_comb begin
		case (csr_adr_ex)
			ex_pkg::CSR_MSTATUS:  csr_rd_data = {24'd0, mpie, 3'd0, csr_mie_bit, 3'd0};
			ex_pkg::CSR_MTVEC:    csr_rd_data = {mtvec, 2'b00};
			ex_pkg::CSR_MSCRATCH: csr_rd_data = mscratch;
			ex_pkg::CSR_MEPC:     csr_rd_data = {mepc, 2'b00};
			ex_pkg::CSR_MCAUSE:   csr_rd_data = mcause;
			default:              csr_rd_data = 32'd0;
		endcase
	end

	// new value per op
	// set or clear with zero source leaves the csr untouched
	always_comb begin
		case (alu_code_ex)
			ex_pkg::CSR_RW, ex_pkg::CSR_RWI: begin
				wdata = src;
				wr_ok = 1'b1;
			end
			ex_pkg::CSR_RS, ex_pkg::CSR_RSI: begin
				wdata = csr_rd_data | src;
				wr_ok = (src != 32'd0);
			end
			ex_pkg::CSR_RC, ex_pkg::CSR_RCI: begin
				wdata = csr_rd_data & ~src;
				wr_ok = (src != 32'd0);
			end
			default: begin
				wdata = csr_rd_data;
				wr_ok = 1'b0;
			end
		endcase
	end

	assign wr_en = csr_we & wr_ok & ~stall;

	// trap request is already stall and purge gated upstream
	assign trap_en = trap_condition_ex;
	assign mret_en = (op_class_ex == ex_pkg::OP_MRET) & ~stall;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			csr_mie_bit <= 1'b0;
			mpie        <= 1'b0;
			mtvec       <= MTVEC_RESET;
			mscratch    <= 32'd0;
			mepc        <= 30'd0;
			mcause      <= 32'd0;
		end else if (trap_en) begin
			// stack mie, disable interrupts in the handler
			mepc        <= pc_ex;
			mcause      <= (op_class_ex == ex_pkg::OP_ECALL) ?
				ex_pkg::CAUSE_ECALL_M : ex_pkg::CAUSE_ILLEGAL;
			mpie        <= csr_mie_bit;
			csr_mie_bit <= 1'b0;
		end else if (mret_en) begin
			csr_mie_bit <= mpie;
			mpie        <= 1'b1;
		end else if (wr_en) begin
			case (csr_adr_ex)
				ex_pkg::CSR_MSTATUS: begin
					// only mie (bit 3) and mpie (bit 7) exist
					csr_mie_bit <= wdata[3];
					mpie        <= wdata[7];
				end
				ex_pkg::CSR_MTVEC:    mtvec    <= wdata[31:2];
				ex_pkg::CSR_MSCRATCH: mscratch <= wdata;
				ex_pkg::CSR_MEPC:     mepc     <= wdata[31:2];
				ex_pkg::CSR_MCAUSE:   mcause   <= wdata;
				default: begin
					// unimplemented address, write dropped
				end
			endcase
		end
	end

endmodule

/* verilog/ex_branch.sv */
// branch unit: condition evaluation, jump target, pc+4 and fetch redirect
`timescale 1ns/1ps

module ex_branch (
	input  ex_pkg::op_class_t op_class_ex,
	input  ex_pkg::alu_code_t alu_code_ex,
	input  logic              cmp_eq,
	input  logic              cmp_lt,
	input  logic              cmp_ltu,
	input  ex_pkg::word_t     adr_base,
	input  ex_pkg::word_t     adr_ofs,
	input  ex_pkg::pc_t       pc_ex,
	input  ex_pkg::pc_t       mtvec,
	input  ex_pkg::pc_t       mepc,
	input  logic              stall,
	input  logic              jmp_purge_ma,
	output ex_pkg::pc_t       jmp_adr_ex,
	output logic              jmp_condition_ex,
	output logic              trap_condition_ex,
	output ex_pkg::word_t     pcp4,
	output ex_pkg::word_t     target
);

	logic br_taken;
	logic redirect;
	logic trap_op;
	logic live;

	always_comb begin
		case (alu_code_ex)
			ex_pkg::BR_BEQ:  br_taken = cmp_eq;
			ex_pkg::BR_BNE:  br_taken = ~cmp_eq;
			ex_pkg::BR_BLT:  br_taken = cmp_lt;
			ex_pkg::BR_BGE:  br_taken = ~cmp_lt;
			ex_pkg::BR_BLTU: br_taken = cmp_ltu;
			ex_pkg::BR_BGEU: br_taken = ~cmp_ltu;
			default:         br_taken = 1'b0;
		endcase
	end

	assign redirect = (op_class_ex == ex_pkg::OP_JAL) |
		(op_class_ex == ex_pkg::OP_JALR) |
		(op_class_ex == ex_pkg::OP_MRET) |
		((op_class_ex == ex_pkg::OP_BR) & br_taken);

	assign trap_op = (op_class_ex == ex_pkg::OP_ECALL) | (op_class_ex == ex_pkg::OP_ILLEGAL);

	// a stalled or purged instruction must not steer fetch
	assign live = ~stall & ~jmp_purge_ma;

	assign jmp_condition_ex  = live & redirect;
	assign trap_condition_ex = live & trap_op;

	// also the auipc result
	assign target = adr_base + adr_ofs;
	assign pcp4   = {pc_ex, 2'b00} + 32'd4;

	// trap vector and mret return address override the adder
	always_comb begin
		if (trap_op) begin
			jmp_adr_ex = mtvec;
		end else if (op_class_ex == ex_pkg::OP_MRET) begin
			jmp_adr_ex = mepc;
		end else begin
			jmp_adr_ex = target[31:2];
		end
	end

endmodule

/* verilog/ex_alu.sv */
// integer alu: shared add/sub, shifts, set-less-than, logic ops and branch compare flags
`timescale 1ns/1ps

module ex_alu (
	input  ex_pkg::word_t     rs1_sel,
	input  ex_pkg::word_t     rs2_sel,
	input  ex_pkg::alu_code_t alu_code_ex,
	input  logic              alu_sub_ex,
	input  ex_pkg::op_class_t op_class_ex,
	output ex_pkg::word_t     alu_result,
	output logic              cmp_eq,
	output logic              cmp_lt,
	output logic              cmp_ltu
);

	logic          sub_en;
	logic          is_ldst;
	logic [4:0]    shamt;
	ex_pkg::word_t rs2_inv;
	ex_pkg::word_t sum;
	ex_pkg::word_t sll_res;
	ex_pkg::word_t srl_res;
	ex_pkg::word_t sra_res;
	ex_pkg::word_t sr_res;

	// subtract only for register-register ops, addi ignores the flag
	assign sub_en  = (op_class_ex == ex_pkg::OP_ALU) & alu_sub_ex;
	assign rs2_inv = rs2_sel ^ {32{sub_en}};

	// two's complement via inversion plus carry in
	assign sum = rs1_sel + rs2_inv + {31'd0, sub_en};

	// shift amount is the low five bits either way
	assign shamt   = rs2_sel[4:0];
	assign sll_res = rs1_sel << shamt;
	assign srl_res = rs1_sel >> shamt;
	assign sra_res = ex_pkg::word_t'($signed(rs1_sel) >>> shamt);

	// funct7 bit 5 picks arithmetic shift for srai too
	assign sr_res = alu_sub_ex ? sra_res : srl_res;

	// compare flags, reused by the branch unit
	assign cmp_eq  = (rs1_sel == rs2_sel);
	assign cmp_lt  = ($signed(rs1_sel) < $signed(rs2_sel));
	assign cmp_ltu = (rs1_sel < rs2_sel);

	// loads and stores carry funct3 as width, result is the address
	assign is_ldst = (op_class_ex == ex_pkg::OP_LD) | (op_class_ex == ex_pkg::OP_ST);

	always_comb begin
		if (is_ldst) begin
			alu_result = sum;
		end else begin
			case (alu_code_ex)
				ex_pkg::ALU_ADD:  alu_result = sum;
				ex_pkg::ALU_SLL:  alu_result = sll_res;
				ex_pkg::ALU_SLT:  alu_result = {31'd0, cmp_lt};
				ex_pkg::ALU_SLTU: alu_result = {31'd0, cmp_ltu};
				ex_pkg::ALU_XOR:  alu_result = rs1_sel ^ rs2_sel;
				ex_pkg::ALU_SR:   alu_result = sr_res;
				ex_pkg::ALU_OR:   alu_result = rs1_sel | rs2_sel;
				ex_pkg::ALU_AND:  alu_result = rs1_sel & rs2_sel;
				default:          alu_result = sum;
			endcase
		end
	end

endmodule

/* verilog/ex_operand_sel.sv */
// operand selection: register forwarding, alu second operand and address adder inputs
`timescale 1ns/1ps

module ex_operand_sel (
	input  ex_pkg::op_class_t op_class_ex,
	input  ex_pkg::word_t     rs1_data_ex,
	input  ex_pkg::word_t     rs2_data_ex,
	input  ex_pkg::word_t     imm_ex,
	input  ex_pkg::pc_t       pc_ex,
	input  ex_pkg::fwd_sel_t  fwd_rs1_ex,
	input  ex_pkg::fwd_sel_t  fwd_rs2_ex,
	input  ex_pkg::word_t     rd_data_ma,
	input  ex_pkg::word_t     wbk_data_wb,
	input  ex_pkg::word_t     wbk_data_wb2,
	output ex_pkg::word_t     rs1_sel,
	output ex_pkg::word_t     rs2_sel,
	output ex_pkg::word_t     st_data,
	output ex_pkg::word_t     adr_base,
	output ex_pkg::word_t     adr_ofs
);

	ex_pkg::word_t rs1_fwd;
	ex_pkg::word_t rs2_fwd;
	logic          use_imm;

	// one forwarding mux, shared by both source registers
	function automatic ex_pkg::word_t fwd_mux(
		input ex_pkg::fwd_sel_t sel,
		input ex_pkg::word_t    reg_val
	);
		case (sel)
			ex_pkg::FWD_MA:  fwd_mux = rd_data_ma;
			ex_pkg::FWD_WB:  fwd_mux = wbk_data_wb;
			ex_pkg::FWD_WB2: fwd_mux = wbk_data_wb2;
			default:         fwd_mux = reg_val;
		endcase
	endfunction

	assign rs1_fwd = fwd_mux(fwd_rs1_ex, rs1_data_ex);
	assign rs2_fwd = fwd_mux(fwd_rs2_ex, rs2_data_ex);

	// immediate replaces rs2 for alui and the address of loads and stores
	assign use_imm = (op_class_ex == ex_pkg::OP_ALUI) |
		(op_class_ex == ex_pkg::OP_LD) |
		(op_class_ex == ex_pkg::OP_ST);

	assign rs1_sel = rs1_fwd;
	assign rs2_sel = use_imm ? imm_ex : rs2_fwd;

	// store data is always the forwarded rs2
	assign st_data = rs2_fwd;

	// jalr adds to rs1, every other target is pc relative
	assign adr_base = (op_class_ex == ex_pkg::OP_JALR) ? rs1_fwd : {pc_ex, 2'b00};
	assign adr_ofs  = imm_ex;

endmodule

/* verilog/ex_pkg.sv */
// execute stage package: shared word types, operation classes and CSR encodings
package ex_pkg;

	// widths that carry a meaning
	typedef logic [31:0] word_t;
	typedef logic [29:0] pc_t;
	typedef logic [4:0]  reg_adr_t;
	typedef logic [11:0] csr_adr_t;
	typedef logic [2:0]  alu_code_t;
	typedef logic [3:0]  op_class_t;
	typedef logic [1:0]  fwd_sel_t;
	typedef logic [2:0]  csr_op_t;

	// alu funct3
	localparam alu_code_t ALU_ADD  = 3'd0;
	localparam alu_code_t ALU_SLL  = 3'd1;
	localparam alu_code_t ALU_SLT  = 3'd2;
	localparam alu_code_t ALU_SLTU = 3'd3;
	localparam alu_code_t ALU_XOR  = 3'd4;
	localparam alu_code_t ALU_SR   = 3'd5;
	localparam alu_code_t ALU_OR   = 3'd6;
	localparam alu_code_t ALU_AND  = 3'd7;

	// branch funct3
	localparam alu_code_t BR_BEQ  = 3'd0;
	localparam alu_code_t BR_BNE  = 3'd1;
	localparam alu_code_t BR_BLT  = 3'd4;
	localparam alu_code_t BR_BGE  = 3'd5;
	localparam alu_code_t BR_BLTU = 3'd6;
	localparam alu_code_t BR_BGEU = 3'd7;

	// operation class from decode
	localparam op_class_t OP_NOP     = 4'd0;
	localparam op_class_t OP_ALU     = 4'd1;
	localparam op_class_t OP_ALUI    = 4'd2;
	localparam op_class_t OP_LUI     = 4'd3;
	localparam op_class_t OP_AUIPC   = 4'd4;
	localparam op_class_t OP_LD      = 4'd5;
	localparam op_class_t OP_ST      = 4'd6;
	localparam op_class_t OP_JAL     = 4'd7;
	localparam op_class_t OP_JALR    = 4'd8;
	localparam op_class_t OP_BR      = 4'd9;
	localparam op_class_t OP_CSR     = 4'd10;
	localparam op_class_t OP_ECALL   = 4'd11;
	localparam op_class_t OP_MRET    = 4'd12;
	localparam op_class_t OP_ILLEGAL = 4'd13;

	// forwarding source
	localparam fwd_sel_t FWD_NONE = 2'd0;
	localparam fwd_sel_t FWD_MA   = 2'd1;
	localparam fwd_sel_t FWD_WB   = 2'd2;
	localparam fwd_sel_t FWD_WB2  = 2'd3;

	// csr funct3, bit 2 marks the immediate forms
	localparam csr_op_t CSR_RW  = 3'b001;
	localparam csr_op_t CSR_RS  = 3'b010;
	localparam csr_op_t CSR_RC  = 3'b011;
	localparam csr_op_t CSR_RWI = 3'b101;
	localparam csr_op_t CSR_RSI = 3'b110;
	localparam csr_op_t CSR_RCI = 3'b111;

	// machine csr addresses
	localparam csr_adr_t CSR_MSTATUS  = 12'h300;
	localparam csr_adr_t CSR_MTVEC    = 12'h305;
	localparam csr_adr_t CSR_MSCRATCH = 12'h340;
	localparam csr_adr_t CSR_MEPC     = 12'h341;
	localparam csr_adr_t CSR_MCAUSE   = 12'h342;

	// exception causes
	localparam word_t CAUSE_ILLEGAL = 32'd2;
	localparam word_t CAUSE_ECALL_M = 32'd11;

endpackage
